/* tb_cipher_model.svh */
localparam logic [127:0] TOY_KEY = 128'h3c6e_f372_a54f_f53a_510e_527f_9b05_688c;

// toy keyed permutation in place of the block cipher
// same function on the responder side and in the reference model
function automatic logic [127:0] toy_cipher(logic [127:0] blk);
  logic [127:0] t;
  t = blk ^ TOY_KEY;
  t = {t[98:0], t[127:99]};                   // rotate left by 29
  return t ^ {TOY_KEY[63:0], TOY_KEY[127:64]};
endfunction

/* gcm_checker.sv */
`timescale 1ns/1ps

module gcm_checker (
  input  logic            clk,
  input  logic            rstn,
  input  logic            start,
  input  gcm_pkg::block_t data_in,
  input  logic            blk_valid,
  input  gcm_pkg::size_t  blk_size,
  input  logic            blk_aad,
  input  logic            blk_last,
  input  logic            encrypt,
  input  logic            accept,
  input  logic            cipher_start,
  input  logic            cipher_done,
  input  logic            data_valid,
  input  logic            tag_valid,
  input  gcm_pkg::block_t data_out,
  input  gcm_pkg::size_t  data_size,
  output int              error_count
);
  import gcm_pkg::*;
  `include "tb_cipher_model.svh"

  block_t h;
  block_t ek0;
  block_t y;         // model counter block
  block_t acc;       // model ghash state
  block_t tag_exp;
  len_t   aad_bytes;
  len_t   txt_bytes;
  int     keys_done;
  int     tags_pending;
  logic   req_open;  // cipher request waiting for its done
  block_t data_q[$];
  size_t  size_q[$];

  // bitwise multiply in GF(2^128) with the first bit of the block at bit 127
  function automatic block_t gf_mult(block_t x, block_t hv);
    block_t z;
    block_t v;
    z = '0;
    v = hv;
    for (int i = 127; i >= 0; i--) begin
      if (x[i]) z = z ^ v;
      v = v[0] ? ((v >> 1) ^ GHASH_R) : (v >> 1);
    end
    return z;
  endfunction

  function automatic block_t byte_mask(size_t s);
    return ~block_t'(0) << ((15 - int'(s)) * 8);
  endfunction

  // expected output block of one accepted block
  function automatic block_t ref_block(block_t d, size_t s, logic aad, logic enc);
    block_t al;
    block_t ks;
    block_t res;
    al = (d << ((15 - int'(s)) * 8)) & byte_mask(s);   // valid bytes to the top
    res = '0;
    if (aad) begin
      acc = gf_mult(acc ^ al, h);
      aad_bytes = aad_bytes + len_t'(s) + 64'd1;
    end else begin
      y = {y[127:32], y[31:0] + 32'd1};                 // inc32
      ks = toy_cipher(y);
      res = (ks ^ al) & byte_mask(s);
      acc = gf_mult(acc ^ (enc ? res : al), h);
      txt_bytes = txt_bytes + len_t'(s) + 64'd1;
    end
    return res;
  endfunction

  always @(negedge clk) begin
    block_t exp_d;
    size_t  exp_s;
    if (!rstn) begin
      keys_done    = 0;
      tags_pending = 0;
      req_open     = 1'b0;
      if (accept || cipher_start || data_valid || tag_valid) begin
        $display("accept, cipher_start or a valid output is high during reset at %0t", $time);
        error_count++;
      end
    end else begin
      if (start) begin
        h         = toy_cipher('0);
        ek0       = toy_cipher(data_in);
        y         = data_in;
        acc       = '0;
        aad_bytes = '0;
        txt_bytes = '0;
        keys_done = 0;
      end
      if (cipher_done && keys_done < 2) keys_done++;
      if (accept && keys_done < 2) begin
        $display("accept rose before key setup finished at %0t", $time);
        error_count++;
      end
      if (cipher_start) begin
        if (req_open) begin
          $display("cipher_start pulsed while a request was still open at %0t", $time);
          error_count++;
        end
        req_open = 1'b1;
      end
      if (cipher_done) req_open = 1'b0;
      if (blk_valid && accept) begin
        exp_d = ref_block(data_in, blk_size, blk_aad, encrypt);
        if (!blk_aad) begin
          data_q.push_back(exp_d);
          size_q.push_back(blk_size);
        end
        if (blk_last) begin
          acc = gf_mult(acc ^ {aad_bytes << 3, txt_bytes << 3}, h);   // length block
          tag_exp = ek0 ^ acc;
          tags_pending++;
        end
      end
      if (data_valid) begin
        if (data_q.size() == 0) begin
          $display("data_valid pulsed with no text block in flight at %0t", $time);
          error_count++;
        end else begin
          exp_d = data_q.pop_front();
          exp_s = size_q.pop_front();
          if (data_out !== exp_d || data_size !== exp_s) begin
            $display("error at %0t: data_out %h size %0d, expected %h size %0d",
                     $time, data_out, data_size, exp_d, exp_s);
            error_count++;
          end
        end
      end
      if (tag_valid) begin
        if (tags_pending == 0) begin
          $display("tag_valid pulsed with no message ended at %0t", $time);
          error_count++;
        end else begin
          tags_pending--;
          if (data_out !== tag_exp || data_size !== 4'd15) begin
            $display("error at %0t: tag %h size %0d, expected %h size 15",
                     $time, data_out, data_size, tag_exp);
            error_count++;
          end
        end
      end
    end
  end

  initial error_count = 0;

endmodule

/* gcm_core.sv */
`timescale 1ns/1ps

module gcm_core (
  input  logic            clk,
  input  logic            rstn,
  input  logic            start,
  input  logic            blk_valid,
  input  gcm_pkg::block_t data_in,
  input  gcm_pkg::size_t  blk_size,
  input  logic            blk_aad,
  input  logic            blk_last,
  input  logic            encrypt,
  output logic            accept,
  output logic            cipher_start,
  output gcm_pkg::block_t cipher_block,
  input  logic            cipher_done,
  input  gcm_pkg::block_t cipher_result,
  output logic            data_valid,
  output logic            tag_valid,
  output gcm_pkg::block_t data_out,
  output gcm_pkg::size_t  data_size
);
  import gcm_pkg::*;

  in_blk_s blk;
  in_blk_s ct_blk;
  block_t  ghash_operand;
  block_t  digest;
  logic    load_y0;
  logic    inc_ctr;
  logic    take_blk;
  logic    sel_zero;
  logic    sel_len;
  logic    ghash_start;
  logic    ghash_done;
  logic    h_load;
  logic    ek0_load;
  logic    text_out_en;
  logic    tag_out_en;

  assign blk = '{data: data_in, size: blk_size, aad: blk_aad, last: blk_last};

  gcm_ctrl i_ctrl (
    .clk, .rstn, .start, .blk_valid, .blk, .cipher_done, .ghash_done,
    .accept, .cipher_start, .load_y0, .inc_ctr, .take_blk, .sel_zero, .sel_len,
    .ghash_start, .h_load, .ek0_load, .text_out_en, .tag_out_en
  );

  gcm_text_path i_text (
    .clk, .rstn, .data_in, .blk, .load_y0, .take_blk, .inc_ctr, .sel_zero, .sel_len,
    .encrypt, .cipher_result, .cipher_block, .ghash_operand, .ct_blk
  );

  // accumulator restarts with each new message
  gcm_ghash i_ghash (
    .clk, .rstn, .h_load, .h_in(cipher_result), .clear(load_y0), .ghash_start,
    .ghash_operand, .digest, .ghash_done
  );

  gcm_output i_out (
    .clk, .rstn, .ek0_load, .cipher_result, .text_out_en, .tag_out_en, .ct_blk,
    .digest, .data_valid, .tag_valid, .data_out, .data_size
  );

endmodule

/* gcm_ctrl.sv */
`timescale 1ns/1ps

module gcm_ctrl (
  input  logic             clk,
  input  logic             rstn,
  input  logic             start,
  input  logic             blk_valid,
  input  gcm_pkg::in_blk_s blk,
  input  logic             cipher_done,
  input  logic             ghash_done,
  output logic             accept,
  output logic             cipher_start,
  output logic             load_y0,
  output logic             inc_ctr,
  output logic             take_blk,
  output logic             sel_zero,
  output logic             sel_len,
  output logic             ghash_start,
  output logic             h_load,
  output logic             ek0_load,
  output logic             text_out_en,
  output logic             tag_out_en
);
  import gcm_pkg::*;

  gcm_state_e state;
  gcm_state_e next_state;
  logic       entered;   // first cycle after a state change
  logic       aad_q;     // flags of the block in flight
  logic       last_q;

  always_comb begin
    next_state = state;
    case (state)
      st_idle:       if (start)       next_state = st_get_h;
      st_get_h:      if (cipher_done) next_state = st_get_ek0;
      st_get_ek0:    if (cipher_done) next_state = st_accept;
      st_accept:     if (blk_valid)   next_state = blk.aad ? st_ghash_run : st_ctr_inc;
      st_ctr_inc:                     next_state = st_text_crypt;
      st_text_crypt: if (cipher_done) next_state = st_ghash_run;
      st_ghash_run: begin
        if (ghash_done) begin
          next_state = last_q ? st_len_hash : st_accept;
        end
      end
      st_len_hash:   if (ghash_done)  next_state = st_tag_out;
      st_tag_out:                     next_state = st_idle;
      default:                        next_state = st_idle;
    endcase
  end

  assign accept      = (state == st_accept);
  assign take_blk    = accept && blk_valid;
  assign load_y0     = (state == st_idle) && start;
  assign sel_zero    = (state == st_idle) || (state == st_get_h);   // hash key request
  assign inc_ctr     = (state == st_ctr_inc);
  assign sel_len     = (state == st_len_hash);
  assign h_load      = (state == st_get_h) && cipher_done;
  assign ek0_load    = (state == st_get_ek0) && cipher_done;
  assign text_out_en = (state == st_text_crypt) && cipher_done;
  assign tag_out_en  = sel_len && ghash_done;

  // one request per entry into a cipher state
  assign cipher_start = entered && ((state == st_get_h) || (state == st_get_ek0) ||
                                    (state == st_text_crypt));

  // text blocks start hashing on the keystream cycle itself
  // aad and the length block start on entry
  assign ghash_start = text_out_en ||
                       (entered && (sel_len || ((state == st_ghash_run) && aad_q)));

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      state   <= st_idle;
      entered <= 1'b0;
      aad_q   <= 1'b0;
      last_q  <= 1'b0;
    end else begin
      state   <= next_state;
      entered <= (next_state != state);
      if (take_blk) begin
        aad_q  <= blk.aad;
        last_q <= blk.last;
      end
    end
  end

endmodule

/* gcm_ghash.sv */
`timescale 1ns/1ps

module gcm_ghash (
  input  logic            clk,
  input  logic            rstn,
  input  logic            h_load,
  input  gcm_pkg::block_t h_in,
  input  logic            clear,
  input  logic            ghash_start,
  input  gcm_pkg::block_t ghash_operand,
  output gcm_pkg::block_t digest,
  output logic            ghash_done
);
  import gcm_pkg::*;

  block_t                  h;
  block_t                  v;
  block_t                  z;
  block_t                  b;       // operand digits not yet consumed
  block_t                  acc;
  block_t                  v_sel;
  block_t                  z_sel;
  block_t                  b_sel;
  block_t                  v_out;
  block_t                  z_out;
  logic                    busy;
  logic [GHASH_STEP_W-1:0] step;

  // the start cycle already runs the first digit
  assign v_sel = ghash_start ? h : v;
  assign z_sel = ghash_start ? '0 : z;
  assign b_sel = ghash_start ? (ghash_operand ^ acc) : b;

  gf_mult_digit i_step (
    .v_in    (v_sel),
    .z_in    (z_sel),
    .b_digit (b_sel[127 -: GHASH_DIGIT]),
    .v_out   (v_out),
    .z_out   (z_out)
  );

  assign ghash_done = busy && (step == GHASH_STEP_W'(GHASH_STEPS - 1));
  assign digest     = ghash_done ? z_out : acc;   // tag sees the final product

  always_ff @(posedge clk) begin
    if (h_load) begin
      h <= h_in;
    end
    v <= v_out;
    z <= z_out;
    b <= b_sel << GHASH_DIGIT;
  end

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      busy <= 1'b0;
      step <= '0;
      acc  <= '0;
    end else begin
      if (ghash_start) begin
        busy <= 1'b1;
        step <= GHASH_STEP_W'(1);
      end else if (ghash_done) begin
        busy <= 1'b0;
        step <= '0;
      end else if (busy) begin
        step <= step + 1'b1;
      end
      if (clear) begin
        acc <= '0;
      end else if (ghash_done) begin
        acc <= z_out;
      end
    end
  end

endmodule

/* gcm_output.sv */
`timescale 1ns/1ps

module gcm_output (
  input  logic             clk,
  input  logic             rstn,
  input  logic             ek0_load,
  input  gcm_pkg::block_t  cipher_result,
  input  logic             text_out_en,
  input  logic             tag_out_en,
  input  gcm_pkg::in_blk_s ct_blk,
  input  gcm_pkg::block_t  digest,
  output logic             data_valid,
  output logic             tag_valid,
  output gcm_pkg::block_t  data_out,
  output gcm_pkg::size_t   data_size
);
  import gcm_pkg::*;

  block_t ek0;   // E(K,Y0)

  always_ff @(posedge clk) begin
    if (ek0_load) begin
      ek0 <= cipher_result;
    end
    if (tag_out_en) begin
      data_out  <= ek0 ^ digest;
      data_size <= size_t'(BLOCK_BYTES - 1);   // tag is always a full block
    end else if (text_out_en) begin
      data_out  <= ct_blk.data;
      data_size <= ct_blk.size;
    end
  end

  // single cycle strobes
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      data_valid <= 1'b0;
      tag_valid  <= 1'b0;
    end else begin
      data_valid <= text_out_en;
      tag_valid  <= tag_out_en;
    end
  end

endmodule

/* gcm_pkg.sv */
package gcm_pkg;

  localparam int BLOCK_BYTES   = 16;
  localparam int GHASH_DIGIT   = 16;                    // operand bits per multiply step
  localparam int GHASH_STEPS   = 128 / GHASH_DIGIT;
  localparam int GHASH_STEP_W  = $clog2(GHASH_STEPS);

  typedef logic [127:0] block_t;
  typedef logic [3:0]   size_t;                         // byte count minus one
  typedef logic [63:0]  len_t;                          // byte counter
  typedef logic [31:0]  ctr_t;                          // low word of the counter block

  // reduction polynomial x^128 + x^7 + x^2 + x + 1 in GCM bit order
  localparam block_t GHASH_R = {8'he1, 120'd0};

  // one block as offered by the source
  typedef struct packed {
    block_t data;
    size_t  size;
    logic   aad;                                        // high for aad, low for text
    logic   last;
  } in_blk_s;

  typedef enum logic [3:0] {
    st_idle,
    st_get_h,        // cipher of the zero block
    st_get_ek0,      // cipher of y0
    st_accept,
    st_ctr_inc,
    st_text_crypt,
    st_ghash_run,
    st_len_hash,
    st_tag_out
  } gcm_state_e;

endpackage

/* gcm_text_path.sv */
`timescale 1ns/1ps

module gcm_text_path (
  input  logic             clk,
  input  logic             rstn,
  input  gcm_pkg::block_t  data_in,
  input  gcm_pkg::in_blk_s blk,
  input  logic             load_y0,
  input  logic             take_blk,
  input  logic             inc_ctr,
  input  logic             sel_zero,
  input  logic             sel_len,
  input  logic             encrypt,
  input  gcm_pkg::block_t  cipher_result,
  output gcm_pkg::block_t  cipher_block,
  output gcm_pkg::block_t  ghash_operand,
  output gcm_pkg::in_blk_s ct_blk
);
  import gcm_pkg::*;

  in_blk_s    cur;        // accepted block
  block_t     y;          // counter block
  len_t       aad_len;
  len_t       txt_len;
  logic       taken;
  logic       is_text;    // set by the counter step
  logic [6:0] pad_bits;   // unused bits below the valid bytes
  block_t     aligned;
  block_t     keep;
  block_t     ct;
  ctr_t       ctr_next;

  // valid bytes sit low on input and move to the top of the block
  assign pad_bits = {size_t'(BLOCK_BYTES - 1) - cur.size, 3'b000};
  assign aligned  = cur.data << pad_bits;
  assign keep     = ~block_t'(0) << pad_bits;
  assign ct       = (cipher_result ^ aligned) & keep;
  assign ctr_next = y[31:0] + ctr_t'(1);   // inc32

  assign cipher_block = sel_zero ? '0 : y;
  assign ct_blk       = '{data: ct, size: cur.size, aad: cur.aad, last: cur.last};

  always_comb begin
    if (sel_len) begin
      ghash_operand = {aad_len[60:0], 3'b000, txt_len[60:0], 3'b000};   // bit lengths
    end else if (is_text && encrypt) begin
      ghash_operand = ct;
    end else begin
      ghash_operand = aligned;
    end
  end

  always_ff @(posedge clk) begin
    if (take_blk) begin
      cur <= blk;
    end
    if (load_y0) begin
      y <= data_in;
    end else if (inc_ctr) begin
      y <= {y[127:32], ctr_next};
    end
  end

  // a text block steps the counter in the cycle after it is taken
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      aad_len <= '0;
      txt_len <= '0;
      taken   <= 1'b0;
      is_text <= 1'b0;
    end else begin
      taken <= take_blk;
      if (take_blk) begin
        is_text <= 1'b0;
      end else if (inc_ctr) begin
        is_text <= 1'b1;
      end
      if (load_y0) begin
        aad_len <= '0;
        txt_len <= '0;
      end else if (taken && inc_ctr) begin
        txt_len <= txt_len + len_t'(cur.size) + len_t'(1);
      end else if (taken) begin
        aad_len <= aad_len + len_t'(cur.size) + len_t'(1);
      end
    end
  end

endmodule

/* gf_mult_digit.sv */
`timescale 1ns/1ps

module gf_mult_digit (
  input  gcm_pkg::block_t                   v_in,
  input  gcm_pkg::block_t                   z_in,
  input  logic [gcm_pkg::GHASH_DIGIT-1:0]   b_digit,
  output gcm_pkg::block_t                   v_out,
  output gcm_pkg::block_t                   z_out
);
  import gcm_pkg::*;

  // bit 127 holds the x^0 coefficient so a right shift multiplies by x
  always_comb begin
    block_t v;
    block_t z;
    v = v_in;
    z = z_in;
    for (int i = GHASH_DIGIT - 1; i >= 0; i--) begin
      if (b_digit[i]) begin
        z = z ^ v;
      end
      if (v[0]) begin
        v = (v >> 1) ^ GHASH_R;   // x^128 folds back in
      end else begin
        v = v >> 1;
      end
    end
    v_out = v;
    z_out = z;
  end

endmodule

/* run.sh */
#!/bin/sh
# build and run the gcm testbench with verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tb_gcm -f sources.f -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

out=$(./obj_dir/Vtb_gcm)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -qx "Finished with no errors"; then
  exit 0
fi
exit 1

/* sources.f */
+incdir+.
gcm_pkg.sv
gf_mult_digit.sv
gcm_ghash.sv
gcm_text_path.sv
gcm_ctrl.sv
gcm_output.sv
gcm_core.sv
gcm_checker.sv
tb_gcm.sv

/* tb_gcm.sv */
`timescale 1ns/1ps

module tb_gcm;
  import gcm_pkg::*;
  `include "tb_cipher_model.svh"

  logic   clk;
  logic   rstn;
  logic   start;
  logic   blk_valid;
  block_t data_in;
  size_t  blk_size;
  logic   blk_aad;
  logic   blk_last;
  logic   encrypt;
  logic   accept;
  logic   cipher_start;
  block_t cipher_block;
  logic   cipher_done;
  block_t cipher_result;
  logic   data_valid;
  logic   tag_valid;
  block_t data_out;
  size_t  data_size;
  int     chk_errors;

  logic [31:0] lfsr;
  int          tb_errors;
  int          timeouts;
  logic        tag_seen;
  block_t      ct_q[$];        // outputs of the current message
  block_t      aad_mem[8];
  block_t      txt_mem[8];
  int          n_aad;
  int          n_txt;
  size_t       last_size;

  gcm_core i_dut (.*);

  gcm_checker i_chk (
    .clk, .rstn, .start, .data_in, .blk_valid, .blk_size, .blk_aad, .blk_last,
    .encrypt, .accept, .cipher_start, .cipher_done, .data_valid, .tag_valid, .data_out,
    .data_size, .error_count(chk_errors)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // galois lfsr stepped once per bit
  function automatic logic [127:0] rand_bits(int n);
    logic [127:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'hA300_0000) : (lfsr >> 1);
      r = {r[126:0], lfsr[0]};
    end
    return r;
  endfunction

  // cipher responder with a random latency of 1 to 6 cycles
  initial begin
    block_t blk;
    int     delay;
    forever begin
      @(negedge clk);
      if (cipher_start) begin
        blk   = cipher_block;
        delay = 1 + int'(rand_bits(3)) % 6;
        repeat (delay) @(posedge clk);
        #2;
        cipher_done   = 1'b1;
        cipher_result = toy_cipher(blk);
        @(posedge clk);
        #2;
        cipher_done = 1'b0;
      end
    end
  end

  always @(negedge clk) begin
    if (data_valid) ct_q.push_back(data_out);
    if (tag_valid) tag_seen = 1'b1;
  end

  task automatic wait_accept();
    int n;
    n = 0;
    @(posedge clk);
    #2;
    while (!accept && timeouts == 0) begin
      n++;
      if (n > 500) begin
        $display("timeout while waiting for accept");
        timeouts++;
      end
      @(posedge clk);
      #2;
    end
  endtask

  task automatic wait_tag();
    int n;
    n = 0;
    while (!tag_seen && timeouts == 0) begin
      n++;
      if (n > 2000) begin
        $display("timeout while waiting for the tag");
        timeouts++;
      end
      @(posedge clk);
    end
  endtask

  task automatic send_block(block_t d, size_t s, logic aad, logic last);
    wait_accept();
    blk_valid = 1'b1;
    data_in   = d;
    blk_size  = s;
    blk_aad   = aad;
    blk_last  = last;
    @(posedge clk);
    #2;
    blk_valid = 1'b0;
  endtask

  task automatic make_message(int na, int nt, size_t ls);
    n_aad     = na;
    n_txt     = nt;
    last_size = ls;
    for (int i = 0; i < na; i++) aad_mem[i] = rand_bits(128);
    for (int i = 0; i < nt; i++) txt_mem[i] = rand_bits(128);
  endtask

  task automatic run_message(block_t iv, logic enc);
    logic fin;
    ct_q.delete();
    tag_seen = 1'b0;
    @(posedge clk);
    #2;
    encrypt = enc;
    start   = 1'b1;
    data_in = iv;
    @(posedge clk);
    #2;
    start = 1'b0;
    for (int i = 0; i < n_aad; i++) begin
      fin = (n_txt == 0) && (i == n_aad - 1);
      send_block(aad_mem[i], fin ? last_size : size_t'(15), 1'b1, fin);
    end
    for (int i = 0; i < n_txt; i++) begin
      fin = (i == n_txt - 1);
      send_block(txt_mem[i], fin ? last_size : size_t'(15), 1'b0, fin);
    end
    wait_tag();
  endtask

  initial begin
    block_t iv;
    block_t pt[8];
    int     pad;
    lfsr = 32'd2778;
    tb_errors = 0;
    timeouts = 0;
    rstn = 1'b0;
    start = 1'b0;
    blk_valid = 1'b0;
    data_in = '0;
    blk_size = '0;
    blk_aad = 1'b0;
    blk_last = 1'b0;
    encrypt = 1'b1;
    cipher_done = 1'b0;
    cipher_result = '0;
    repeat (16) @(posedge clk);
    #2;
    rstn = 1'b1;

    make_message(0, 3, 15);                    // full blocks only
    run_message(rand_bits(128), 1'b1);
    for (int k = 0; k < 15; k++) begin         // every partial size
      make_message(k % 2, 1 + int'(rand_bits(2)), size_t'(k));
      run_message(rand_bits(128), 1'b1);
    end
    make_message(2, 2, size_t'(rand_bits(4)));
    run_message(rand_bits(128), 1'b1);

    // decrypt the ciphertext of an encrypted message with the same iv and aad
    make_message(1, 3, 6);
    iv = rand_bits(128);
    run_message(iv, 1'b1);
    for (int i = 0; i < n_txt; i++) begin
      pad = (i == n_txt - 1) ? (15 - int'(last_size)) * 8 : 0;
      pt[i] = txt_mem[i] << pad;
      txt_mem[i] = ct_q[i] >> pad;
    end
    run_message(iv, 1'b0);
    for (int i = 0; i < n_txt; i++) begin
      if (i >= ct_q.size() || ct_q[i] !== pt[i]) begin
        $display("error at %0t: decrypted block %0d does not match the plaintext", $time, i);
        tb_errors++;
      end
    end

    make_message(3, 0, 4);                     // aad only
    run_message(rand_bits(128), 1'b1);
    repeat (4) @(posedge clk);

    $display("checker errors %0d, testbench errors %0d, timeouts %0d",
             chk_errors, tb_errors, timeouts);
    if (chk_errors == 0 && tb_errors == 0 && timeouts == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule
